// File: src/bch_mode_pkg.sv
`default_nettype none

package bch_mode_pkg;

	// ========================================================================
	// word width, widest parity (normal frames, t=12)
	// ========================================================================
	localparam int bch_word_w = 192;

	// ========================================================================
	// per-mode tables, index [frame_mode][ldpc_mode]
	// frame_mode 0 is normal, 1 is short
	// ========================================================================

	// K_bch/8 information bytes
	localparam logic [15:0] k_bytes_table [0:1][0:15] = '{
		'{
			16'd2001, 16'd2676, 16'd3216, 16'd4026,  // 1/4 1/3 2/5 1/2
			16'd4836, 16'd5380, 16'd6051, 16'd6456,  // 3/5 2/3 3/4 4/5
			16'd6730, 16'd7184, 16'd7274,            // 5/6 8/9 9/10
			16'd192, 16'd192, 16'd192, 16'd192, 16'd192  // unused codes
		},
		'{
			16'd384, 16'd654, 16'd789, 16'd879,      // 1/4 1/3 2/5 1/2
			16'd1194, 16'd1329, 16'd1464, 16'd1554,  // 3/5 2/3 3/4 4/5
			16'd1644, 16'd1779,                      // 5/6 8/9
			16'd168, 16'd168, 16'd168, 16'd168, 16'd168, 16'd168  // unused codes
		}
	};

	// parity bytes, t=12 -> 24, t=10 -> 20, t=8 -> 16, short t=12 -> 21
	localparam logic [4:0] q_bytes_table [0:1][0:15] = '{
		'{
			5'd24, 5'd24, 5'd24, 5'd24, 5'd24, 5'd20, 5'd24, 5'd24,
			5'd20, 5'd16, 5'd16, 5'd24, 5'd24, 5'd24, 5'd24, 5'd24
		},
		'{
			5'd21, 5'd21, 5'd21, 5'd21, 5'd21, 5'd21, 5'd21, 5'd21,
			5'd21, 5'd21, 5'd21, 5'd21, 5'd21, 5'd21, 5'd21, 5'd21
		}
	};

	// aligner start count, (1 - k_bytes) mod q_bytes
	localparam logic [4:0] init_cnt_table [0:1][0:15] = '{
		'{
			5'd16, 5'd13, 5'd1, 5'd7, 5'd13, 5'd1, 5'd22, 5'd1,
			5'd11, 5'd1, 5'd7, 5'd1, 5'd1, 5'd1, 5'd1, 5'd1
		},
		'{
			5'd16, 5'd19, 5'd10, 5'd4, 5'd4, 5'd16, 5'd7, 5'd1,
			5'd16, 5'd7, 5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd1
		}
	};

endpackage

`default_nettype wire

// File: src/bch_poly_pkg.sv
`default_nettype none

package bch_poly_pkg;

	import bch_mode_pkg::*;

	// ========================================================================
	// minimal polynomials g1..g12, bit i is the x^i coefficient
	// ========================================================================
	localparam logic [16:0] normal_min_poly [0:11] = '{
		17'h1002D, 17'h10173, 17'h10FBD, 17'h15A55,
		17'h11F2F, 17'h1F7B5, 17'h1AF65, 17'h17367,
		17'h10EA1, 17'h175A7, 17'h13A2D, 17'h11AE3
	};

	localparam logic [14:0] short_min_poly [0:11] = '{
		15'h402B, 15'h4941, 15'h4647, 15'h5591,
		15'h6B55, 15'h6389, 15'h6CE5, 15'h4F21,
		15'h460F, 15'h5A49, 15'h5811, 15'h65EF
	};

	// product of the first t minimal polys, leading x^deg dropped
	function automatic logic [bch_word_w-1:0] gen_poly(input logic short_frm, input int t);
		logic [bch_word_w:0] acc;
		logic [bch_word_w:0] prod;
		logic [16:0]         fac;
		int                  deg;
		acc = 1;
		deg = short_frm ? 14 * t : 16 * t;
		for (int i = 0; i < t; i++) begin
			fac  = short_frm ? {2'b00, short_min_poly[i]} : normal_min_poly[i];
			prod = '0;
			for (int j = 0; j < 17; j++) begin
				if (fac[j])
					prod = prod ^ (acc << j);
			end
			acc = prod;
		end
		acc[deg] = 1'b0;
		return acc[bch_word_w-1:0];
	endfunction

	localparam logic [bch_word_w-1:0] bch_poly_n12 = gen_poly(1'b0, 12);  // degree 192
	localparam logic [bch_word_w-1:0] bch_poly_n10 = gen_poly(1'b0, 10);  // degree 160
	localparam logic [bch_word_w-1:0] bch_poly_n8  = gen_poly(1'b0, 8);   // degree 128
	localparam logic [bch_word_w-1:0] bch_poly_s12 = gen_poly(1'b1, 12);  // degree 168

endpackage

`default_nettype wire

// File: src/bch_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bch_frame_ctrl
	import bch_mode_pkg::*;
(
	input  wire        sys_clk,
	input  wire        rst_n,
	input  wire        fs_en,
	input  wire        frame_start,
	input  wire        frame_mode,
	input  wire  [3:0] ldpc_mode,
	output logic       init_vld,
	output logic       frame_vld,
	output logic       word_last,
	output logic       data_vld_dly,
	output logic       ready
);

	logic        start;
	logic        last_byte;
	logic [15:0] byte_cnt;     // info bytes still to come
	logic [4:0]  par_cnt;
	logic [1:0]  vld_sr;
	logic [1:0]  last_sr;
	logic [15:0] k_bytes;
	logic [4:0]  q_bytes;

	assign k_bytes = k_bytes_table[frame_mode][ldpc_mode];
	assign q_bytes = q_bytes_table[frame_mode][ldpc_mode];

	assign start     = frame_start & ready;
	assign init_vld  = start;
	assign last_byte = frame_vld & (byte_cnt == 16'd1);

	// aligner emits the final oe two strobes after the last byte
	assign word_last    = last_sr[1];
	assign data_vld_dly = vld_sr[1];  // lines up with the output delay line

	// ========================================================================
	// information byte window
	// ========================================================================
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			frame_vld <= 1'b0;
			byte_cnt  <= 16'd0;
			vld_sr    <= 2'b00;
			last_sr   <= 2'b00;
		end else if (fs_en) begin
			vld_sr  <= {vld_sr[0], frame_vld};
			last_sr <= {last_sr[0], last_byte};
			if (start) begin
				frame_vld <= 1'b1;
				byte_cnt  <= k_bytes;
			end else if (frame_vld) begin
				byte_cnt <= byte_cnt - 16'd1;
				if (last_byte)
					frame_vld <= 1'b0;
			end
		end
	end

	// ========================================================================
	// ready, held low until the last parity byte has left
	// ========================================================================
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			ready   <= 1'b1;
			par_cnt <= 5'd0;
		end else if (fs_en) begin
			if (start)
				ready <= 1'b0;
			if (last_byte) begin
				par_cnt <= q_bytes + 5'd2;  // 2 strobes of pipeline, then parity
			end else if (par_cnt != 5'd0) begin
				par_cnt <= par_cnt - 5'd1;
				if (par_cnt == 5'd1)
					ready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/bchencoder_data_align.sv
`timescale 1ns/1ps
`default_nettype none

module bchencoder_data_align
	import bch_mode_pkg::*;
(
	input  wire                   sys_clk,
	input  wire                   fs_en,
	input  wire                   rst_n,
	input  wire                   frame_mode,  // 0 normal, 1 short
	input  wire  [3:0]            ldpc_mode,
	input  wire                   init_vld,
	input  wire                   frame_vld,
	input  wire  [7:0]            byte_in,
	output logic                  oe,
	output logic [bch_word_w-1:0] byte_out
);

	logic [7:0] byte_dly;
	logic       frame_vld_dly;
	logic [4:0] byte_cnt;   // position inside the current word
	logic [4:0] cnt_wrap;
	logic [4:0] cnt_init;

	assign cnt_wrap = q_bytes_table[frame_mode][ldpc_mode] - 5'd1;
	assign cnt_init = init_cnt_table[frame_mode][ldpc_mode];

	// ========================================================================
	// one strobe input delay
	// ========================================================================
	always_ff @(posedge sys_clk) begin
		if (fs_en)
			byte_dly <= byte_in;
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			frame_vld_dly <= 1'b0;
		end else if (fs_en) begin
			frame_vld_dly <= frame_vld;
		end
	end

	// ========================================================================
	// word phase counter
	// the start count pads the first word so the last word closes on the
	// last information byte
	// ========================================================================
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			byte_cnt <= 5'd0;
		end else if (fs_en) begin
			if (init_vld) begin
				byte_cnt <= cnt_init;
			end else if (frame_vld_dly) begin
				if (byte_cnt == cnt_wrap)
					byte_cnt <= 5'd0;
				else
					byte_cnt <= byte_cnt + 5'd1;
			end
		end
	end

	// ========================================================================
	// word shift register
	// ========================================================================
	always_ff @(posedge sys_clk) begin
		if (fs_en) begin
			if (init_vld)
				byte_out <= '0;  // zero padding for the first word
			else if (frame_vld_dly)
				byte_out <= {byte_out[bch_word_w-9:0], byte_dly};
		end
	end

	// count 0 marks the byte that completes a word
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			oe <= 1'b0;
		end else if (fs_en) begin
			oe <= frame_vld_dly & (byte_cnt == 5'd0);
		end
	end

endmodule

`default_nettype wire

// File: src/bch_word_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module bch_word_encoder
	import bch_mode_pkg::*, bch_poly_pkg::*;
(
	input  wire                   sys_clk,
	input  wire                   rst_n,
	input  wire                   fs_en,
	input  wire                   frame_mode,
	input  wire  [3:0]            ldpc_mode,
	input  wire                   init_vld,
	input  wire                   word_oe,
	input  wire  [bch_word_w-1:0] word_data,
	input  wire                   word_last,
	output logic                  parity_vld,
	output logic [bch_word_w-1:0] parity_word  // right aligned
);

	logic [4:0]            q_bytes;
	logic [7:0]            q_bits;
	logic [7:0]            pad_bits;
	logic [bch_word_w-1:0] poly_sel;
	logic [bch_word_w-1:0] poly_al;
	logic [bch_word_w-1:0] data_al;
	logic [bch_word_w-1:0] rem_q;    // remainder, kept left aligned
	logic [bch_word_w-1:0] rem_nxt;

	assign q_bytes  = q_bytes_table[frame_mode][ldpc_mode];
	assign q_bits   = {q_bytes, 3'b000};
	assign pad_bits = 8'(bch_word_w) - q_bits;

	always_comb begin
		case (q_bytes)
			5'd20:   poly_sel = bch_poly_n10;
			5'd16:   poly_sel = bch_poly_n8;
			5'd21:   poly_sel = bch_poly_s12;
			default: poly_sel = bch_poly_n12;
		endcase
	end

	// left aligning also drops the stale bytes above the low Q bits
	assign poly_al = poly_sel << pad_bits;
	assign data_al = word_data << pad_bits;

	// ========================================================================
	// (rem + word) * x^Q mod g, one shift step per parity bit
	// ========================================================================
	always_comb begin
		rem_nxt = rem_q ^ data_al;
		for (int i = 0; i < bch_word_w; i++) begin
			if (i < q_bits) begin
				if (rem_nxt[bch_word_w-1])
					rem_nxt = (rem_nxt << 1) ^ poly_al;
				else
					rem_nxt = rem_nxt << 1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (fs_en) begin
			if (init_vld)
				rem_q <= '0;
			else if (word_oe)
				rem_q <= rem_nxt;
			if (word_oe & word_last)
				parity_word <= rem_nxt >> pad_bits;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			parity_vld <= 1'b0;
		end else if (fs_en) begin
			parity_vld <= word_oe & word_last;
		end
	end

endmodule

`default_nettype wire

// File: src/bch_stream_out.sv
`timescale 1ns/1ps
`default_nettype none

module bch_stream_out
	import bch_mode_pkg::*;
(
	input  wire                   sys_clk,
	input  wire                   rst_n,
	input  wire                   fs_en,
	input  wire                   frame_mode,
	input  wire  [3:0]            ldpc_mode,
	input  wire  [7:0]            byte_in,
	input  wire                   data_vld_dly,
	input  wire                   parity_vld,
	input  wire  [bch_word_w-1:0] parity_word,
	output logic                  out_vld,
	output logic [7:0]            out_byte,
	output logic                  out_parity
);

	logic [4:0]            q_bytes;
	logic [7:0]            pad_bits;
	logic [1:0][7:0]       dly_line;  // stages 1 and 2, out_byte is stage 3
	logic [bch_word_w-1:0] par_al;
	logic [bch_word_w-1:0] par_sr;
	logic [4:0]            par_cnt;   // parity bytes still in par_sr

	assign q_bytes  = q_bytes_table[frame_mode][ldpc_mode];
	assign pad_bits = 8'(bch_word_w) - {q_bytes, 3'b000};
	assign par_al   = parity_word << pad_bits;  // msb parity byte on top

	// ========================================================================
	// byte path
	// first parity byte goes out straight on parity_vld, which lands on the
	// strobe after the last data byte leaves stage 3
	// ========================================================================
	always_ff @(posedge sys_clk) begin
		if (fs_en) begin
			dly_line <= {dly_line[0], byte_in};
			if (parity_vld) begin
				out_byte <= par_al[bch_word_w-1 -: 8];
				par_sr   <= par_al << 8;
			end else if (par_cnt != 5'd0) begin
				out_byte <= par_sr[bch_word_w-1 -: 8];
				par_sr   <= par_sr << 8;
			end else begin
				out_byte <= dly_line[1];
			end
		end
	end

	// ========================================================================
	// flags
	// ========================================================================
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			out_vld    <= 1'b0;
			out_parity <= 1'b0;
			par_cnt    <= 5'd0;
		end else if (fs_en) begin
			if (parity_vld) begin
				out_vld    <= 1'b1;
				out_parity <= 1'b1;
				par_cnt    <= q_bytes - 5'd1;
			end else if (par_cnt != 5'd0) begin
				out_vld    <= 1'b1;
				out_parity <= 1'b1;
				par_cnt    <= par_cnt - 5'd1;
			end else begin
				out_vld    <= data_vld_dly;
				out_parity <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/bch_encoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module bch_encoder_top
	import bch_mode_pkg::*;
(
	input  wire        sys_clk,
	input  wire        rst_n,
	input  wire        fs_en,
	input  wire        frame_start,
	input  wire        frame_mode,
	input  wire  [3:0] ldpc_mode,
	input  wire  [7:0] byte_in,
	output logic       ready,
	output logic       out_vld,
	output logic [7:0] out_byte,
	output logic       out_parity
);

	logic                  init_vld;
	logic                  frame_vld;
	logic                  word_last;
	logic                  data_vld_dly;
	logic                  word_oe;
	logic [bch_word_w-1:0] word_data;
	logic                  parity_vld;
	logic [bch_word_w-1:0] parity_word;

	bch_frame_ctrl u_frame_ctrl (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.fs_en        (fs_en),
		.frame_start  (frame_start),
		.frame_mode   (frame_mode),
		.ldpc_mode    (ldpc_mode),
		.init_vld     (init_vld),
		.frame_vld    (frame_vld),
		.word_last    (word_last),
		.data_vld_dly (data_vld_dly),
		.ready        (ready)
	);

	bchencoder_data_align u_data_align (
		.sys_clk    (sys_clk),
		.fs_en      (fs_en),
		.rst_n      (rst_n),
		.frame_mode (frame_mode),
		.ldpc_mode  (ldpc_mode),
		.init_vld   (init_vld),
		.frame_vld  (frame_vld),
		.byte_in    (byte_in),
		.oe         (word_oe),
		.byte_out   (word_data)
	);

	bch_word_encoder u_word_encoder (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.fs_en       (fs_en),
		.frame_mode  (frame_mode),
		.ldpc_mode   (ldpc_mode),
		.init_vld    (init_vld),
		.word_oe     (word_oe),
		.word_data   (word_data),
		.word_last   (word_last),
		.parity_vld  (parity_vld),
		.parity_word (parity_word)
	);

	bch_stream_out u_stream_out (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.fs_en        (fs_en),
		.frame_mode   (frame_mode),
		.ldpc_mode    (ldpc_mode),
		.byte_in      (byte_in),
		.data_vld_dly (data_vld_dly),
		.parity_vld   (parity_vld),
		.parity_word  (parity_word),
		.out_vld      (out_vld),
		.out_byte     (out_byte),
		.out_parity   (out_parity)
	);

endmodule

`default_nettype wire

// File: dv/bch_encoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bch_encoder_tb
	import bch_mode_pkg::*, bch_poly_pkg::*;
();

	localparam int num_vec  = 18;
	localparam int clk_half = 2;  // 4 ns period

	logic       sys_clk;
	logic       rst_n;
	logic       fs_en;
	logic       frame_start;
	logic       frame_mode;
	logic [3:0] ldpc_mode;
	logic [7:0] byte_in;
	logic       ready;
	logic       out_vld;
	logic [7:0] out_byte;
	logic       out_parity;

	logic [7:0] vec_mem [0:4*num_vec-1];  // four fields per vector
	logic [7:0] exp_byte [$];
	logic       exp_par [$];
	logic       exp_rdy [$];
	logic       duty;
	longint     limit_ns;

	bch_encoder_top DUT (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.fs_en       (fs_en),
		.frame_start (frame_start),
		.frame_mode  (frame_mode),
		.ldpc_mode   (ldpc_mode),
		.byte_in     (byte_in),
		.ready       (ready),
		.out_vld     (out_vld),
		.out_byte    (out_byte),
		.out_parity  (out_parity)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(clk_half) sys_clk = ~sys_clk;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_run($sformatf("FAILED %s got 0x%02h expected 0x%02h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("FAILED %s got 0x%01h expected 0x%01h", name, got, exp));
	endtask

	// drives the values that the next strobe samples
	task automatic drive_strobe(input logic start, input logic [7:0] data);
		logic en;
		en = 1'b0;
		while (!en) begin
			@(posedge sys_clk);
			en = duty ? (($urandom % 2) == 1) : 1'b1;
			fs_en       <= en;
			frame_start <= start & en;
			byte_in     <= data;
		end
	endtask

	// normal rates 2/3 and 5/6 use t=10 and rates 8/9 and 9/10 use t=8
	function automatic logic [bch_word_w-1:0] pick_poly(input logic short_frm,
		input logic [3:0] ldpc);
		if (short_frm)
			return bch_poly_s12;
		else if (ldpc == 4'd5 || ldpc == 4'd8)
			return bch_poly_n10;
		else if (ldpc == 4'd9 || ldpc == 4'd10)
			return bch_poly_n8;
		else
			return bch_poly_n12;
	endfunction

	// divides one more byte into the remainder msb first
	function automatic logic [bch_word_w-1:0] shift_byte(input logic [bch_word_w-1:0] rem,
		input logic [7:0] data, input int q_bits, input logic [bch_word_w-1:0] poly);
		logic [bch_word_w-1:0] mask;
		logic                  fb;
		mask = {bch_word_w{1'b1}} >> (bch_word_w - q_bits);  // remainder right aligned
		for (int b = 7; b >= 0; b--) begin
			fb  = data[b] ^ rem[q_bits-1];
			rem = ((rem << 1) & mask) ^ (fb ? poly : '0);
		end
		return rem;
	endfunction

	// ========================================================================
	// stimulus and reference model
	// ========================================================================
	initial begin
		int                    k;
		int                    q;
		int                    gap;
		logic                  f;
		logic [3:0]            l;
		logic [7:0]            data;
		logic [bch_word_w-1:0] rem;
		logic [bch_word_w-1:0] poly;
		void'($urandom(32'h0f1b_6567));
		rst_n       = 1'b0;
		fs_en       = 1'b0;
		frame_start = 1'b0;
		frame_mode  = 1'b0;
		ldpc_mode   = 4'd0;
		byte_in     = 8'h00;
		duty        = 1'b0;
		limit_ns    = 0;
		$readmemh("dv/bch_vectors.txt", vec_mem);
		if ($isunknown(vec_mem[4*num_vec-1]))
			stop_run("vector file holds fewer vectors than expected");
		for (int v = 0; v < num_vec; v++) begin
			f        = vec_mem[4*v][0];
			l        = vec_mem[4*v+1][3:0];
			gap      = vec_mem[4*v+3];
			limit_ns += longint'(k_bytes_table[f][l] + q_bytes_table[f][l] + gap) * 4 * 4 * 2;
		end
		repeat (8) @(posedge sys_clk);
		rst_n <= 1'b1;
		for (int v = 0; v < num_vec; v++) begin
			f    = vec_mem[4*v][0];
			l    = vec_mem[4*v+1][3:0];
			duty = vec_mem[4*v+2][0];
			gap  = vec_mem[4*v+3];
			do begin
				drive_strobe(1'b0, 8'h00);
				@(negedge sys_clk);
			end while (!ready);
			drive_strobe(1'b0, 8'h00);
			frame_mode <= f;  // previous frame has fully left
			ldpc_mode  <= l;
			repeat (gap) drive_strobe(1'b0, 8'h00);
			k    = k_bytes_table[f][l];
			q    = q_bytes_table[f][l];
			poly = pick_poly(f, l);
			rem  = '0;
			drive_strobe(1'b1, 8'h00);
			for (int i = 0; i < k; i++) begin
				data = 8'($urandom);
				drive_strobe(1'b0, data);
				rem = shift_byte(rem, data, 8 * q, poly);
				exp_byte.push_back(data);
				exp_par.push_back(1'b0);
				exp_rdy.push_back(1'b0);
			end
			for (int j = 0; j < q; j++) begin
				exp_byte.push_back(8'(rem >> (8 * (q - 1 - j))));  // msb byte first
				exp_par.push_back(1'b1);
				exp_rdy.push_back(j == q - 1);
			end
		end
		while (exp_byte.size() != 0)
			drive_strobe(1'b0, 8'h00);
		repeat (8) drive_strobe(1'b0, 8'h00);  // catch stray output
		$display("TESTS PASSED");
		$finish;
	end

	// ========================================================================
	// output checker
	// ========================================================================
	initial begin
		logic strobe;
		logic busy;   // inside the output burst of a frame
		logic last;
		busy = 1'b0;
		forever begin
			@(posedge sys_clk);
			strobe = fs_en & rst_n;
			@(negedge sys_clk);
			if (strobe && out_vld) begin  // one compare per output strobe
				if (exp_byte.size() == 0) begin
					stop_run("output byte seen while no byte was expected");
				end else begin
					last = exp_rdy.pop_front();
					check_byte("out_byte", out_byte, exp_byte.pop_front());
					check_flag("out_parity", out_parity, exp_par.pop_front());
					check_flag("ready", ready, last);
					busy = !last;
				end
			end else if (strobe && busy) begin
				check_flag("out_vld", out_vld, 1'b1);  // gap inside data or parity
			end
		end
	end

	initial begin
		wait (rst_n === 1'b1);
		#(limit_ns);
		stop_run("time limit reached, the output stalled before all bytes arrived");
	end

endmodule

`default_nettype wire

// File: dv/bch_vectors.txt
// frame_mode ldpc_mode duty gap, all hex
// duty 0 keeps fs_en high, duty 1 drives it about half the time
1 0 0 00
1 1 1 03
1 2 0 00
1 3 1 00
1 4 0 05
1 5 1 02
1 6 0 00
1 7 1 00
1 8 0 10
1 9 1 00
0 5 0 00
0 8 1 04
0 9 0 00
0 a 1 00
0 0 0 00
0 2 1 07
0 4 0 00
0 7 1 00

// File: filelist.f
src/bch_mode_pkg.sv
src/bch_poly_pkg.sv
src/bch_frame_ctrl.sv
src/bchencoder_data_align.sv
src/bch_word_encoder.sv
src/bch_stream_out.sv
src/bch_encoder_top.sv
dv/bch_encoder_tb.sv
